// ==== tg_pkg.sv ====
package tg_pkg;

	// serial byte from the UART
	typedef logic [7:0] uart_byte_t;

	// one word of the controller write port
	typedef logic [31:0] mem_word_t;

	// command byte address
	typedef logic [29:0] byte_addr_t;

	// burst length field, word count minus one
	typedef logic [5:0] burst_len_t;

	// data bytes in one frame, 1 to 64
	typedef logic [6:0] frame_len_t;

	// frame delimiter
	localparam uart_byte_t start_byte = 8'hff;

	// reply bytes, "d" and "e"
	localparam uart_byte_t done_byte = 8'h64;
	localparam uart_byte_t error_byte = 8'h65;

	// longest frame the write port burst can take
	localparam int max_frame_len = 64;

	// controller instruction code for a plain write
	localparam logic [2:0] cmd_write = 3'b000;

endpackage

// ==== tg_fifo.sv ====
`timescale 1ns/10ps

module tg_fifo #(
	parameter int width = 8,
	parameter int depth = 16
) (
	input logic clk,
	input logic reset,
	input logic push,
	input logic pop,
	input logic [width-1:0] din,
	output logic [width-1:0] dout,
	output logic empty,
	output logic full,
	output logic [$clog2(depth+1)-1:0] count
);
	localparam int aw = (depth > 1) ? $clog2(depth) : 1;
	localparam int cw = $clog2(depth + 1);

	logic [width-1:0] mem [depth];
	logic [aw-1:0] rd_ptr;
	logic [aw-1:0] wr_ptr;

	// head shown without a read cycle
	assign dout = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == cw'(depth));

	// storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= din;
		end
	end

	// pointers wrap at depth, which need not be a power of two
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// callers own the flow control
	push_when_full: assert property (@(posedge clk) disable iff (reset) push |-> !full);
	pop_when_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

// ==== tg_frame_parser.sv ====
`timescale 1ns/10ps

module tg_frame_parser #(
	parameter int data_depth = 64
) (
	input logic clk,
	input logic reset,
	input logic rx_done_tick,
	input tg_pkg::uart_byte_t rx_data_out,
	output logic data_push,
	output tg_pkg::mem_word_t data_word,
	input logic [$clog2(data_depth+1)-1:0] data_count,
	input logic desc_full,
	output logic desc_push,
	output tg_pkg::byte_addr_t desc_addr,
	output tg_pkg::frame_len_t desc_len,
	output logic reject_strobe
);
	import tg_pkg::*;

	typedef enum logic [1:0] {
		idle,
		address,
		length,
		payload
	} state_t;

	state_t state;
	byte_addr_t addr;
	frame_len_t len;
	frame_len_t cnt;
	logic [1:0] addr_cnt;
	logic accept;
	logic last_byte;

	// frame must fit both the descriptor queue and the free data space
	assign accept = (rx_data_out != '0) && (int'(rx_data_out) <= max_frame_len) &&
		!desc_full && (int'(rx_data_out) <= data_depth - int'(data_count));

	assign last_byte = (cnt == frame_len_t'(len - 1'b1));

	// descriptor fields stay put until the next frame's address bytes
	assign desc_addr = addr;
	assign desc_len = len;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			addr_cnt <= '0;
			cnt <= '0;
			data_push <= 1'b0;
			desc_push <= 1'b0;
			reject_strobe <= 1'b0;
		end else begin
			data_push <= 1'b0;
			desc_push <= 1'b0;
			reject_strobe <= 1'b0;
			if (rx_done_tick) begin
				case (state)
					idle: begin
						// anything but the start byte is noise here
						if (rx_data_out == start_byte) begin
							state <= address;
							addr_cnt <= '0;
						end
					end
					address: begin
						addr_cnt <= addr_cnt + 1'b1;
						if (addr_cnt == 2'd3) begin
							state <= length;
						end
					end
					length: begin
						cnt <= '0;
						if (accept) begin
							state <= payload;
						end else begin
							reject_strobe <= 1'b1;
							state <= idle;
						end
					end
					payload: begin
						data_push <= 1'b1;
						cnt <= cnt + 1'b1;
						if (last_byte) begin
							desc_push <= 1'b1;
							state <= idle;
						end
					end
					default: state <= idle;
				endcase
			end
		end
	end

	// address shift, length and data word
	always_ff @(posedge clk) begin
		if (rx_done_tick) begin
			if (state == address) begin
				// top two bits of the first byte fall off
				addr <= {addr[21:0], rx_data_out};
			end
			if (state == length) begin
				len <= frame_len_t'(rx_data_out);
			end
			data_word <= mem_word_t'(rx_data_out);
		end
	end

endmodule

// ==== tg_write_burst.sv ====
`timescale 1ns/10ps

module tg_write_burst (
	input logic clk,
	input logic reset,
	input logic desc_empty,
	input tg_pkg::byte_addr_t desc_addr,
	input tg_pkg::frame_len_t desc_len,
	output logic desc_pop,
	input logic data_empty,
	input tg_pkg::mem_word_t data_head,
	output logic data_pop,
	input logic wr_full,
	output logic wr_en,
	output tg_pkg::mem_word_t wr_data,
	input logic cmd_full,
	output logic cmd_en,
	output logic [2:0] cmd_instr,
	output tg_pkg::burst_len_t cmd_bl,
	output tg_pkg::byte_addr_t cmd_byte_addr,
	output logic done_strobe
);
	import tg_pkg::*;

	typedef enum logic [1:0] {
		idle,
		stream,
		command
	} state_t;

	state_t state;
	byte_addr_t addr;
	frame_len_t len;
	frame_len_t cnt;
	logic last_word;

	// one word per cycle while the write port has room
	assign wr_en = (state == stream) && !wr_full && !data_empty;
	assign data_pop = wr_en;
	assign wr_data = data_head;
	assign last_word = (cnt == frame_len_t'(len - 1'b1));

	// command goes out once the command FIFO has room
	assign cmd_en = (state == command) && !cmd_full;
	assign done_strobe = cmd_en;
	assign cmd_instr = cmd_write;
	assign cmd_bl = burst_len_t'(len - 1'b1);
	assign cmd_byte_addr = addr;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			cnt <= '0;
			desc_pop <= 1'b0;
		end else begin
			desc_pop <= 1'b0;
			case (state)
				idle: begin
					cnt <= '0;
					if (!desc_empty) begin
						// head is latched now, popped next cycle
						desc_pop <= 1'b1;
						state <= stream;
					end
				end
				stream: begin
					if (wr_en) begin
						cnt <= cnt + 1'b1;
						if (last_word) begin
							state <= command;
						end
					end
				end
				command: begin
					if (cmd_en) begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// frame descriptor
	always_ff @(posedge clk) begin
		if ((state == idle) && !desc_empty) begin
			addr <= desc_addr;
			len <= desc_len;
		end
	end

	// a zero or oversized length would wrap the word count
	desc_len_in_range: assert property (@(posedge clk) disable iff (reset)
		desc_pop |-> (len != '0) && (int'(len) <= max_frame_len));

endmodule

// ==== tg_reply_queue.sv ====
`timescale 1ns/10ps

module tg_reply_queue #(
	parameter int reply_depth = 16
) (
	input logic clk,
	input logic reset,
	input logic done_strobe,
	input logic reject_strobe,
	input logic tx_busy,
	output logic tx_start_transmission,
	output tg_pkg::uart_byte_t tx_data_in
);
	import tg_pkg::*;

	logic pending_err;
	logic hold;
	logic reply_push;
	logic reply_empty;
	uart_byte_t reply_byte;

	// done byte wins a tie, the error follows a cycle later
	assign reply_push = done_strobe || reject_strobe || pending_err;
	assign reply_byte = done_strobe ? done_byte : error_byte;

	// hold gives the transmitter a cycle to raise tx_busy
	assign tx_start_transmission = !reply_empty && !tx_busy && !hold;

	always_ff @(posedge clk) begin
		if (reset) begin
			pending_err <= 1'b0;
			hold <= 1'b0;
		end else begin
			pending_err <= done_strobe && (reject_strobe || pending_err);
			hold <= tx_start_transmission;
		end
	end

	tg_fifo #(
		.width($bits(uart_byte_t)),
		.depth(reply_depth)
	) reply_fifo (
		.clk(clk),
		.reset(reset),
		.push(reply_push),
		.pop(tx_start_transmission),
		.din(reply_byte),
		.dout(tx_data_in),
		.empty(reply_empty),
		.full(),
		.count()
	);

	// a second reject before the carried one is pushed would be lost
	no_reject_while_pending: assert property (@(posedge clk) disable iff (reset)
		pending_err |-> !reject_strobe);

endmodule

// ==== traffic_generator.sv ====
`timescale 1ns/10ps

module traffic_generator #(
	parameter int data_depth = 64,
	parameter int desc_depth = 4,
	parameter int reply_depth = 16
) (
	input logic clk,
	input logic reset,
	input logic rx_done_tick,
	input tg_pkg::uart_byte_t rx_data_out,
	input logic tx_busy,
	output logic tx_start_transmission,
	output tg_pkg::uart_byte_t tx_data_in,
	input logic wr_full,
	output logic wr_en,
	output tg_pkg::mem_word_t wr_data,
	input logic cmd_full,
	output logic cmd_en,
	output logic [2:0] cmd_instr,
	output tg_pkg::burst_len_t cmd_bl,
	output tg_pkg::byte_addr_t cmd_byte_addr
);
	import tg_pkg::*;

	// parser to data FIFO
	logic data_push;
	mem_word_t data_word;
	logic [$clog2(data_depth+1)-1:0] data_count;

	// data FIFO to write stage
	logic data_pop;
	logic data_empty;
	mem_word_t data_head;

	// descriptor queue
	logic desc_push;
	logic desc_pop;
	logic desc_full;
	logic desc_empty;
	byte_addr_t desc_addr;
	frame_len_t desc_len;
	byte_addr_t head_addr;
	frame_len_t head_len;

	// reply sources
	logic reject_strobe;
	logic done_strobe;

	tg_frame_parser #(
		.data_depth(data_depth)
	) parser (
		.clk(clk),
		.reset(reset),
		.rx_done_tick(rx_done_tick),
		.rx_data_out(rx_data_out),
		.data_push(data_push),
		.data_word(data_word),
		.data_count(data_count),
		.desc_full(desc_full),
		.desc_push(desc_push),
		.desc_addr(desc_addr),
		.desc_len(desc_len),
		.reject_strobe(reject_strobe)
	);

	tg_fifo #(
		.width($bits(mem_word_t)),
		.depth(data_depth)
	) data_fifo (
		.clk(clk),
		.reset(reset),
		.push(data_push),
		.pop(data_pop),
		.din(data_word),
		.dout(data_head),
		.empty(data_empty),
		.full(),
		.count(data_count)
	);

	// descriptor is address above length
	tg_fifo #(
		.width($bits(byte_addr_t) + $bits(frame_len_t)),
		.depth(desc_depth)
	) desc_fifo (
		.clk(clk),
		.reset(reset),
		.push(desc_push),
		.pop(desc_pop),
		.din({desc_addr, desc_len}),
		.dout({head_addr, head_len}),
		.empty(desc_empty),
		.full(desc_full),
		.count()
	);

	tg_write_burst writer (
		.clk(clk),
		.reset(reset),
		.desc_empty(desc_empty),
		.desc_addr(head_addr),
		.desc_len(head_len),
		.desc_pop(desc_pop),
		.data_empty(data_empty),
		.data_head(data_head),
		.data_pop(data_pop),
		.wr_full(wr_full),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.cmd_full(cmd_full),
		.cmd_en(cmd_en),
		.cmd_instr(cmd_instr),
		.cmd_bl(cmd_bl),
		.cmd_byte_addr(cmd_byte_addr),
		.done_strobe(done_strobe)
	);

	tg_reply_queue #(
		.reply_depth(reply_depth)
	) replies (
		.clk(clk),
		.reset(reset),
		.done_strobe(done_strobe),
		.reject_strobe(reject_strobe),
		.tx_busy(tx_busy),
		.tx_start_transmission(tx_start_transmission),
		.tx_data_in(tx_data_in)
	);

endmodule

// ==== tb_traffic_generator.sv ====
`timescale 1ns/10ps

module tb_traffic_generator;
	import tg_pkg::*;

	logic clk;
	logic reset;
	logic rx_done_tick;
	uart_byte_t rx_data_out;
	logic tx_busy;
	logic tx_start_transmission;
	uart_byte_t tx_data_in;
	logic wr_full;
	logic wr_en;
	mem_word_t wr_data;
	logic cmd_full;
	logic cmd_en;
	logic [2:0] cmd_instr;
	burst_len_t cmd_bl;
	byte_addr_t cmd_byte_addr;

	// pattern stream, see the column notes at the top of the file
	logic [7:0] pat [0:511];

	mem_word_t exp_words [$];
	byte_addr_t exp_cmd_addr [$];
	burst_len_t exp_cmd_bl [$];
	int exp_cmd_words [$];
	uart_byte_t exp_replies [$];

	int errors;
	int checks;
	int words_seen;
	int limit_cycles;
	int stall_mode;
	int cur_mode;
	logic [31:0] rng_state;

	traffic_generator dut0 (
		.clk(clk),
		.reset(reset),
		.rx_done_tick(rx_done_tick),
		.rx_data_out(rx_data_out),
		.tx_busy(tx_busy),
		.tx_start_transmission(tx_start_transmission),
		.tx_data_in(tx_data_in),
		.wr_full(wr_full),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.cmd_full(cmd_full),
		.cmd_en(cmd_en),
		.cmd_instr(cmd_instr),
		.cmd_bl(cmd_bl),
		.cmd_byte_addr(cmd_byte_addr)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// entries the stimulus will walk through, never fewer than the bytes sent
	function automatic int stream_length();
		int i;
		i = 0;
		while (pat[i] != 8'h00) begin
			if (pat[i] == 8'h06) begin
				i = i + 2 + int'(pat[i+1]);
			end else if (pat[i+5] >= 1 && int'(pat[i+5]) <= max_frame_len) begin
				i = i + 6 + int'(pat[i+5]);
			end else begin
				i = i + 6;
			end
		end
		return i;
	endfunction

	function automatic string test_name(input int tag);
		case (tag)
			1: return "single frame";
			2: return "back to back, command port held full";
			3: return "random write and command stalls";
			4: return "rejected lengths";
			5: return "reply order under tx_busy";
			6: return "noise while idle";
			default: return "unknown";
		endcase
	endfunction

	task automatic report(input string msg);
		$display("%0t: %s", $time, msg);
		errors++;
	endtask

	task automatic check_word(input string name, input mem_word_t exp, input mem_word_t got);
		checks++;
		if (got !== exp) begin
			$display("Fail %0t %s: expected %h, got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input byte_addr_t exp, input byte_addr_t got);
		checks++;
		if (got !== exp) begin
			$display("Fail %0t %s: expected %h, got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_bl(input string name, input burst_len_t exp, input burst_len_t got);
		checks++;
		if (got !== exp) begin
			$display("Fail %0t %s: expected %0d, got %0d", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_instr(input string name, input logic [2:0] exp, input logic [2:0] got);
		checks++;
		if (got !== exp) begin
			$display("Fail %0t %s: expected %b, got %b", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t got);
		checks++;
		if (got !== exp) begin
			$display("Fail %0t %s: expected %h, got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	// receiver model, one byte every 4 cycles
	task automatic send_byte(input uart_byte_t b);
		repeat (3) @(posedge clk);
		#1;
		rx_data_out = b;
		rx_done_tick = 1'b1;
		@(posedge clk);
		#1;
		rx_done_tick = 1'b0;
	endtask

	// data bytes are listed only for lengths the parser accepts
	task automatic send_frame(inout int idx);
		logic [31:0] raw;
		int n;
		raw = {pat[idx+1], pat[idx+2], pat[idx+3], pat[idx+4]};
		n = int'(pat[idx+5]);
		send_byte(start_byte);
		for (int i = 1; i <= 4; i++) begin
			send_byte(pat[idx+i]);
		end
		idx = idx + 6;
		if (n >= 1 && n <= max_frame_len) begin
			exp_cmd_addr.push_back(byte_addr_t'(raw));
			exp_cmd_bl.push_back(burst_len_t'(n - 1));
			exp_cmd_words.push_back(n);
			exp_replies.push_back(done_byte);
			for (int i = 0; i < n; i++) begin
				exp_words.push_back(mem_word_t'(pat[idx+i]));
			end
			send_byte(uart_byte_t'(n));
			for (int i = 0; i < n; i++) begin
				send_byte(pat[idx+i]);
			end
			idx = idx + n;
		end else begin
			exp_replies.push_back(error_byte);
			send_byte(uart_byte_t'(n));
		end
	endtask

	task automatic send_noise(inout int idx);
		int n;
		n = int'(pat[idx+1]);
		for (int i = 0; i < n; i++) begin
			send_byte(pat[idx+2+i]);
		end
		idx = idx + 2 + n;
	endtask

	// wait for every expected output, then watch a while for strays
	task automatic drain();
		while (exp_words.size() != 0 || exp_cmd_bl.size() != 0 || exp_replies.size() != 0) begin
			@(posedge clk);
		end
		repeat (24) @(posedge clk);
		#1;
	endtask

	// stall source, mode taken at the edge and applied after it
	always @(posedge clk) begin
		cur_mode = stall_mode;
		#1;
		if (cur_mode == 2) begin
			rng_state = xorshift(rng_state);
			wr_full = (rng_state[1:0] == 2'b00);
			cmd_full = (rng_state[3:2] == 2'b00);
		end else begin
			wr_full = 1'b0;
			cmd_full = (cur_mode == 1);
		end
	end

	// transmitter model, busy for 10 cycles after each start
	always begin
		@(negedge clk);
		if (tx_start_transmission === 1'b1) begin
			@(posedge clk);
			#1;
			tx_busy = 1'b1;
			repeat (10) @(posedge clk);
			#1;
			tx_busy = 1'b0;
		end
	end

	// outputs are settled at the falling edge
	always @(negedge clk) begin
		if (reset === 1'b0) begin
			if (wr_en === 1'b1) begin
				if (wr_full)
					report("wr_en was high while wr_full was high");
				if (exp_words.size() == 0) begin
					report("wr_en came with no word expected");
				end else begin
					check_word("wr_data", exp_words.pop_front(), wr_data);
					words_seen++;
				end
			end
			if (cmd_en === 1'b1) begin
				if (cmd_full)
					report("cmd_en was high while cmd_full was high");
				if (exp_cmd_bl.size() == 0) begin
					report("cmd_en came with no command expected");
				end else begin
					check_addr("cmd_byte_addr", exp_cmd_addr.pop_front(), cmd_byte_addr);
					check_bl("cmd_bl", exp_cmd_bl.pop_front(), cmd_bl);
					check_instr("cmd_instr", cmd_write, cmd_instr);
					if (words_seen != exp_cmd_words.pop_front())
						report($sformatf("command came after %0d words of its frame", words_seen));
				end
				words_seen = 0;
			end
			if (tx_start_transmission === 1'b1) begin
				if (tx_busy)
					report("tx_start_transmission was high while tx_busy was high");
				if (exp_replies.size() == 0)
					report("a reply byte was sent with none expected");
				else
					check_byte("tx_data_in", exp_replies.pop_front(), tx_data_in);
			end
		end
	end

	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout after %0d cycles, still waiting for %0d words, %0d commands, %0d replies",
			limit_cycles, exp_words.size(), exp_cmd_bl.size(), exp_replies.size());
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		int idx;
		int tag;
		int frames;
		int err_before;
		int tests;
		reset = 1'b1;
		rx_done_tick = 1'b0;
		rx_data_out = '0;
		tx_busy = 1'b0;
		wr_full = 1'b0;
		cmd_full = 1'b0;
		stall_mode = 0;
		rng_state = 32'hd957d2cd;
		errors = 0;
		checks = 0;
		words_seen = 0;
		tests = 0;
		for (int i = 0; i < 512; i++) begin
			pat[i] = 8'h00;
		end
		$readmemh("tg_patterns.txt", pat);
		// margin covers draining, stalls and the paced replies
		limit_cycles = stream_length() * 4 + 3000;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		idx = 0;
		while (pat[idx] != 8'h00) begin
			tag = int'(pat[idx]);
			err_before = errors;
			frames = 0;
			stall_mode = (tag == 2) ? 1 : ((tag == 3) ? 2 : 0);
			while (int'(pat[idx]) == tag) begin
				if (tag == 6)
					send_noise(idx);
				else
					send_frame(idx);
				frames++;
			end
			stall_mode = 0;
			drain();
			tests++;
			$display("test %0d, %s: %0d records, %s", tag, test_name(tag), frames,
				(errors == err_before) ? "ok" : "errors found");
		end
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== tg_patterns.txt ====
// columns: test, address bytes msb first, length, data bytes (only for lengths 1 to 64)
// test 06 lines: 06, byte count, noise bytes; a lone 00 ends the stream
// single frame, top address bits dropped
01 c0 12 34 56 0c 00 01 7f 80 ff fe 55 aa 10 20 30 40
// back to back with the command port held full
02 00 00 01 00 04 11 12 13 14
02 00 00 02 00 03 21 22 23
02 00 00 03 00 05 31 32 33 34 35
// random write and command stalls
03 3f ff ff fc 10 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10
03 12 00 00 40 14 a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab ac ad ae af b0 b1 b2 b3
03 00 ab cd e0 09 c1 c2 c3 c4 c5 c6 c7 c8 c9
// lengths 0 and 65
04 00 00 10 00 00
04 00 00 20 00 41
// accepted and rejected frames mixed
05 00 00 00 04 02 de ad
05 00 00 00 08 50
05 00 00 00 0c 01 5a
05 00 00 00 10 00
// noise while idle
06 05 00 12 64 fe 7f
00

// ==== flist.f ====
tg_pkg.sv
tg_fifo.sv
tg_frame_parser.sv
tg_write_burst.sv
tg_reply_queue.sv
traffic_generator.sv
tb_traffic_generator.sv
